/* fpmul_params.svh */
// format widths, bias, register map and rounding codes shared by the fp multiplier RTL and testbench
`ifndef FPMUL_PARAMS_SVH
`define FPMUL_PARAMS_SVH

`define FP_W   32
`define EXP_W  8
`define FRC_W  23
`define PROD_W 48 // 24x24 significand product
`define NORM_W 27 // lead, fraction, guard, round, sticky
`define NUM_PP 9  // radix-8 booth rows
`define PP_W   48
`define BIAS   8'd127

// wishbone register map
`define ADR_W      3
`define REG_X      3'd0
`define REG_Y      3'd1
`define REG_MODE   3'd2
`define REG_RESULT 3'd3
`define REG_STATUS 3'd4

// rounding modes where other codes round as rmm
`define RM_RNE 3'd0
`define RM_RTZ 3'd1
`define RM_RDN 3'd2
`define RM_RUP 3'd3
`define RM_RMM 3'd4

`define NAN_FRC 23'h40_0000 // quiet nan with the fraction msb set

`endif

/* source/fpmul_pkg.sv */
// types shared by the fp multiplier blocks; import where the bus, float or row types are used
`default_nettype none

`include "fpmul_params.svh"

package fpmul_pkg;

  // one float word that the bus side stores raw and the datapath splits
  typedef union packed {
    logic [`FP_W-1:0] raw;
    struct packed {
      logic              sign;
      logic [`EXP_W-1:0] exp;
      logic [`FRC_W-1:0] frc;
    } f;
  } fp32_u;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [`ADR_W-1:0] adr;
    logic [`FP_W-1:0]  dat;
  } wb_req_s;

  typedef struct packed {
    logic             ack;
    logic [`FP_W-1:0] dat;
  } wb_rsp_s;

  typedef struct packed {
    logic nan;
    logic inf;
    logic zer;
    logic ovrf;
    logic udrf;
  } fp_flags_s;

  typedef logic [2:0] round_mode_t;

  // booth rows plus the negation correction row on top
  typedef logic [`NUM_PP:0][`PP_W-1:0] pp_array_t;

endpackage

`default_nettype wire

/* source/fpmul_wb_ctrl.sv */
// wishbone classic slave holding the operand and mode registers and the captured result and status
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module fpmul_wb_ctrl
  import fpmul_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  wb_req_s     wb_req,
  output wb_rsp_s     wb_rsp,
  output fp32_u       op_x,
  output fp32_u       op_y,
  output round_mode_t mode,
  input  fp32_u       fp_z,
  input  fp_flags_s   flags
);

  logic             acc;
  logic             ack_q;
  logic [`FP_W-1:0] rdat_d;
  logic [`FP_W-1:0] rdat_q;
  fp32_u            x_q;
  fp32_u            y_q;
  fp32_u            result_q;
  round_mode_t      mode_q;
  fp_flags_s        status_q;

  assign acc = wb_req.cyc & wb_req.stb & ~ack_q; // one ack per strobe

  always_comb begin
    case (wb_req.adr)
      `REG_X:      rdat_d = x_q.raw;
      `REG_Y:      rdat_d = y_q.raw;
      `REG_MODE:   rdat_d = {{(`FP_W-$bits(round_mode_t)){1'b0}}, mode_q};
      `REG_RESULT: rdat_d = result_q.raw;
      `REG_STATUS: rdat_d = {{(`FP_W-$bits(fp_flags_s)){1'b0}}, status_q};
      default:     rdat_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q  <= 1'b0;
      rdat_q <= '0;
      x_q    <= '0;
      y_q    <= '0;
      mode_q <= `RM_RNE;
    end else begin
      ack_q <= acc;
      if (acc) begin
        rdat_q <= rdat_d;
      end
      if (acc && wb_req.we) begin
        case (wb_req.adr)
          `REG_X:    x_q.raw <= wb_req.dat;
          `REG_Y:    y_q.raw <= wb_req.dat;
          `REG_MODE: mode_q  <= wb_req.dat[$bits(round_mode_t)-1:0];
          default: ; // result and status are read only
        endcase
      end
    end
  end

  // whole datapath settles within one cycle
  always_ff @(posedge clk) begin
    result_q <= fp_z;
    status_q <= flags;
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rdat_q;
  assign op_x       = x_q;
  assign op_y       = y_q;
  assign mode       = mode_q;

endmodule

`default_nettype wire

/* source/booth_pp_gen.sv */
// radix-8 booth partial products of the 24-bit significands for the reduction tree
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module booth_pp_gen
  import fpmul_pkg::*;
(
  input  logic [`FRC_W-1:0] frc_x,
  input  logic [`FRC_W-1:0] frc_y,
  output pp_array_t         pp
);

  localparam int MAG_W = `FRC_W + 4; // 4y plus a clear sign bit

  logic [`FRC_W:0]     sig_y;
  logic [`FRC_W+2:0]   y3;
  logic [3*`NUM_PP:0]  xe; // multiplier with x[-1] and zero pad
  logic [`NUM_PP-1:0]  neg_row;
  logic [`PP_W-1:0]    corr;

  assign sig_y = {1'b1, frc_y};
  assign xe    = {3'b000, 1'b1, frc_x, 1'b0};
  assign y3    = {1'b0, sig_y, 1'b0} + {2'b00, sig_y}; // odd multiple

  for (genvar i = 0; i < `NUM_PP; i++) begin : g_row
    logic [3:0]         grp;
    logic [MAG_W-1:0]   mag;
    logic [`PP_W-1:0]   ext;

    assign grp = xe[3*i+3 -: 4];

    always_comb begin
      case (grp)
        4'b0001, 4'b0010, 4'b1101, 4'b1110: mag = {3'b000, sig_y};
        4'b0011, 4'b0100, 4'b1011, 4'b1100: mag = {2'b00, sig_y, 1'b0};
        4'b0101, 4'b0110, 4'b1001, 4'b1010: mag = {1'b0, y3};
        4'b0111, 4'b1000:                   mag = {1'b0, sig_y, 2'b00};
        default:                            mag = '0;
      endcase
    end

    assign neg_row[i] = grp[3] & ~(&grp);
    assign ext = {{(`PP_W-MAG_W){neg_row[i]}}, mag ^ {MAG_W{neg_row[i]}}};
    assign pp[i] = ext << (3 * i);
  end

  // +1 of each inverted row at that row's weight
  always_comb begin
    corr = '0;
    for (int k = 0; k < `NUM_PP; k++) begin
      corr[3*k] = neg_row[k];
    end
  end

  assign pp[`NUM_PP] = corr;

endmodule

`default_nettype wire

/* source/pp_sum_tree.sv */
// carry-save reduction of the booth rows down to one 48-bit significand product
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module pp_sum_tree
  import fpmul_pkg::*;
(
  input  pp_array_t          pp,
  output logic [`PROD_W-1:0] prod
);

  localparam int ROWS = `NUM_PP + 1;

  function automatic int next_rows(input int n);
    return 2 * (n / 3) + n % 3;
  endfunction

  function automatic int rows_at(input int lev);
    int n;
    n = ROWS;
    for (int k = 0; k < lev; k++) begin
      n = next_rows(n);
    end
    return n;
  endfunction

  function automatic int count_levels();
    int lev;
    lev = 0;
    while (rows_at(lev) > 2) begin
      lev++;
    end
    return lev;
  endfunction

  localparam int LEVELS = count_levels(); // 10 rows take five layers

  pp_array_t lvl [0:LEVELS];

  assign lvl[0] = pp;

  for (genvar l = 0; l < LEVELS; l++) begin : g_lvl
    localparam int N = rows_at(l);
    localparam int G = N / 3;

    for (genvar g = 0; g < G; g++) begin : g_csa
      logic [`PP_W-1:0] a, b, c, maj;
      assign a   = lvl[l][3*g];
      assign b   = lvl[l][3*g+1];
      assign c   = lvl[l][3*g+2];
      assign maj = (a & b) | (a & c) | (b & c);
      assign lvl[l+1][2*g]   = a ^ b ^ c;
      assign lvl[l+1][2*g+1] = {maj[`PP_W-2:0], 1'b0};
    end

    for (genvar r = 3 * G; r < N; r++) begin : g_pass
      assign lvl[l+1][r-G] = lvl[l][r]; // leftover rows skip this layer
    end

    for (genvar r = N - G; r < ROWS; r++) begin : g_zero
      assign lvl[l+1][r] = '0;
    end
  end

  assign prod = lvl[LEVELS][0] + lvl[LEVELS][1]; // final cpa

endmodule

`default_nettype wire

/* source/fp_norm_round.sv */
// normalizes the significand product and rounds it to 24 bits in the selected mode
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module fp_norm_round
  import fpmul_pkg::*;
(
  input  logic               sign,
  input  round_mode_t        mode,
  input  logic [`PROD_W-1:0] prod,
  output logic [`FRC_W-1:0]  frc_z,
  output logic               norm
);

  logic [`PROD_W-1:0] prod_sh;
  logic [`NORM_W-1:0] nrm;
  logic [`FRC_W:0]    sig;
  logic               grd;
  logic               rnd;
  logic               stk;
  logic               inc;
  logic [`FRC_W+1:0]  sum;

  assign prod_sh = prod[`PROD_W-1] ? prod : prod << 1;
  assign nrm = {prod_sh[`PROD_W-1 -: `NORM_W-1], |prod_sh[`PROD_W-`NORM_W:0]};

  assign sig = nrm[`NORM_W-1:3];
  assign grd = nrm[2];
  assign rnd = nrm[1];
  assign stk = nrm[0]; // or of the dropped low bits

  always_comb begin
    case (mode)
      `RM_RNE: inc = grd & (rnd | stk | sig[0]);
      `RM_RTZ: inc = 1'b0;
      `RM_RDN: inc = sign;
      `RM_RUP: inc = ~sign;
      default: inc = grd; // rmm
    endcase
  end

  assign sum = {1'b0, sig} + {{(`FRC_W+1){1'b0}}, inc};

  // carry out of the round shifts the fraction one place
  assign frc_z = sum[`FRC_W+1] ? sum[`FRC_W:1] : sum[`FRC_W-1:0];
  assign norm  = prod[`PROD_W-1] | sum[`FRC_W+1];

endmodule

`default_nettype wire

/* source/fp_exp_except.sv */
// result exponent, range flags and nan/inf/zero handling for the final product word
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module fp_exp_except
  import fpmul_pkg::*;
(
  input  fp32_u             op_x,
  input  fp32_u             op_y,
  input  logic              norm,
  input  logic [`FRC_W-1:0] frc_z,
  output fp32_u             fp_z,
  output fp_flags_s         flags
);

  logic [`EXP_W:0]   exp_sum;
  logic [`EXP_W:0]   bias;
  logic [`EXP_W-1:0] exp_z;
  logic              ovrf, udrf;
  logic              max_x, max_y;
  logic              zero_x, zero_y;
  logic              is_nan, is_inf, is_zer;

  assign exp_sum = {1'b0, op_x.f.exp} + {1'b0, op_y.f.exp};
  assign bias    = {1'b0, `BIAS} - {{`EXP_W{1'b0}}, norm}; // 126 once normalized up

  assign ovrf  = {1'b0, exp_sum} >= ({2'b00, {`EXP_W{1'b1}}} + {1'b0, bias});
  assign udrf  = exp_sum <= bias;
  assign exp_z = exp_sum[`EXP_W-1:0] - bias[`EXP_W-1:0];

  assign max_x  = &op_x.f.exp;
  assign max_y  = &op_y.f.exp;
  assign zero_x = ~|op_x.f.exp; // subnormals flush to zero
  assign zero_y = ~|op_y.f.exp;

  assign is_inf = (max_x & ~|op_x.f.frc) | (max_y & ~|op_y.f.frc) | ovrf;
  assign is_zer = zero_x | zero_y | udrf;
  assign is_nan = (max_x & |op_x.f.frc) | (max_y & |op_y.f.frc)
                | (max_x & zero_y) | (max_y & zero_x);

  always_comb begin
    fp_z.f.sign = op_x.f.sign ^ op_y.f.sign;
    case ({is_nan, is_inf, is_zer})
      3'b000: begin
        fp_z.f.exp = exp_z;
        fp_z.f.frc = frc_z;
      end
      3'b010: begin
        fp_z.f.exp = '1;
        fp_z.f.frc = '0;
      end
      3'b001: begin
        fp_z.f.exp = '0;
        fp_z.f.frc = '0;
      end
      default: begin // any mix ends as nan
        fp_z.f.exp = '1;
        fp_z.f.frc = `NAN_FRC;
      end
    endcase
  end

  assign flags = '{nan: is_nan, inf: is_inf, zer: is_zer, ovrf: ovrf, udrf: udrf};

endmodule

`default_nettype wire

/* source/fpmul_top.sv */
// wishbone fp multiplier top with the bus slave around the combinational datapath
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module fpmul_top
  import fpmul_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_s wb_req,
  output wb_rsp_s wb_rsp
);

  fp32_u              op_x;
  fp32_u              op_y;
  round_mode_t        mode;
  pp_array_t          pp;
  logic [`PROD_W-1:0] prod;
  logic [`FRC_W-1:0]  frc_z;
  logic               norm;
  fp32_u              fp_z;
  fp_flags_s          flags;

  fpmul_wb_ctrl i_fpmul_wb_ctrl (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .op_x   (op_x),
    .op_y   (op_y),
    .mode   (mode),
    .fp_z   (fp_z),
    .flags  (flags)
  );

  booth_pp_gen i_booth_pp_gen (
    .frc_x (op_x.f.frc),
    .frc_y (op_y.f.frc),
    .pp    (pp)
  );

  pp_sum_tree i_pp_sum_tree (
    .pp   (pp),
    .prod (prod)
  );

  fp_norm_round i_fp_norm_round (
    .sign  (op_x.f.sign ^ op_y.f.sign),
    .mode  (mode),
    .prod  (prod),
    .frc_z (frc_z),
    .norm  (norm)
  );

  fp_exp_except i_fp_exp_except (
    .op_x  (op_x),
    .op_y  (op_y),
    .norm  (norm),
    .frc_z (frc_z),
    .fp_z  (fp_z),
    .flags (flags)
  );

endmodule

`default_nettype wire

/* sim/tb_fp_model.svh */
// lcg, reference model and bus tasks included inside the fp multiplier testbench module
// pseudo random source with a fixed seed
logic [31:0] lcg_state = 32'hf8ab_60cf;

function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// expected {nan, inf, zer, ovrf, udrf, result word} from the integer product
function automatic logic [36:0] ref_mul(input logic [31:0] x, input logic [31:0] y,
                                        input logic [2:0] mode);
  logic [47:0] p;
  logic [47:0] ps;
  logic [24:0] sum;
  logic [8:0]  esum;
  logic [8:0]  bias;
  logic        sgn, inc, nrm, ovrf, udrf, mx, my, nan, inf, zer;
  logic [31:0] z;
  sgn = x[31] ^ y[31];
  p   = {24'b0, 1'b1, x[22:0]} * {24'b0, 1'b1, y[22:0]};
  ps  = p[47] ? p : p << 1;
  case (mode)
    `RM_RNE: inc = ps[23] & (ps[22] | (|ps[21:0]) | ps[24]);
    `RM_RTZ: inc = 1'b0;
    `RM_RDN: inc = sgn;
    `RM_RUP: inc = ~sgn;
    default: inc = ps[23]; // rmm and spare codes
  endcase
  sum  = {1'b0, ps[47:24]} + {24'b0, inc};
  nrm  = p[47] | sum[24];
  esum = {1'b0, x[30:23]} + {1'b0, y[30:23]};
  bias = 9'd127 - {8'b0, nrm};
  ovrf = esum >= 9'd255 + bias;
  udrf = esum <= bias;
  mx   = &x[30:23];
  my   = &y[30:23];
  inf  = (mx & ~|x[22:0]) | (my & ~|y[22:0]) | ovrf;
  zer  = ~|x[30:23] | ~|y[30:23] | udrf;
  nan  = (mx & |x[22:0]) | (my & |y[22:0]) | (mx & ~|y[30:23]) | (my & ~|x[30:23]);
  z    = {sgn, 31'b0};
  if (nan || (inf && zer)) begin
    z[30:0] = {8'hff, `NAN_FRC};
  end else if (inf) begin
    z[30:23] = 8'hff;
  end else if (!zer) begin
    z[30:0] = {esum[7:0] - bias[7:0], sum[24] ? sum[23:1] : sum[22:0]};
  end
  return {nan, inf, zer, ovrf, udrf, z};
endfunction

// one wishbone classic transfer held until the ack
task automatic wb_xfer(input logic we, input logic [`ADR_W-1:0] adr, input logic [31:0] wdat,
                       output logic [31:0] rdat);
  @(posedge clk);
  wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
  @(negedge clk);
  while (!wb_rsp.ack) begin
    @(negedge clk);
  end
  rdat = wb_rsp.dat;
  @(posedge clk);
  wb_req <= '0;
endtask

task automatic wb_write(input logic [`ADR_W-1:0] adr, input logic [31:0] wdat);
  logic [31:0] unused;
  wb_xfer(1'b1, adr, wdat, unused);
endtask

task automatic wb_read(input logic [`ADR_W-1:0] adr, output logic [31:0] rdat);
  wb_xfer(1'b0, adr, 32'h0, rdat);
endtask

/* sim/tb_fpmul.sv */
// top level testbench of the wishbone fp multiplier that the file list builds and runs
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_params.svh"

module tb_fpmul
  import fpmul_pkg::*;
();

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 8;
  localparam int N_RNE      = 150;
  localparam int N_MODE     = 10; // random pairs per rounding mode
  localparam int N_SPECIAL  = 8;
  localparam int N_RANGE    = 8;
  localparam int N_XFERS    = 14 + 4 * N_RNE + 6 * (2 + 4 * (N_MODE + 2)) + 2
                              + 4 * (N_SPECIAL + N_RANGE);
  localparam int TIMEOUT_NS = (RST_CYCLES + 10 * N_XFERS) * PERIOD;

  localparam logic [63:0] SPECIAL [N_SPECIAL] = '{
    64'h7fc0_0000_3f80_0000, // nan x 1
    64'h7f80_0000_4000_0000, // inf x 2
    64'h7f80_0000_0000_0000, // inf x 0
    64'h0001_2345_4040_0000, // subnormal x 3
    64'h8000_0000_40a0_0000,
    64'h7f80_0001_ff80_0000,
    64'hff80_0000_c040_0000,
    64'h3f80_0000_3f80_0000
  };
  // exponent pairs around the overflow and underflow edges
  localparam logic [15:0] RANGE_EXP [N_RANGE] = '{
    16'hfe81, 16'hc0bf, 16'hbfbf, 16'hbebf, 16'h3f3f, 16'h403f, 16'h017e, 16'h027e
  };

  logic    clk;
  logic    rst_n;
  wb_req_s wb_req;
  wb_rsp_s wb_rsp;

  `include "tb_fp_model.svh"

  fpmul_top i_fpmul_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want)
      else stop_with_failure($sformatf("Error: %s got 0x%08h expected 0x%08h",
                                       name, got, want));
  endtask

  // normal operand with exponent 100..163 so products stay in range
  function automatic logic [31:0] rand_normal(input logic any_sign);
    logic [31:0] f;
    logic [31:0] e;
    f = next_rand();
    e = next_rand();
    return {any_sign & e[31], 8'd100 + {2'b00, e[30:25]}, f[31:9]};
  endfunction

  task automatic check_pair(input logic [31:0] x, input logic [31:0] y, input logic [2:0] mode);
    logic [36:0] want;
    logic [31:0] got;
    want = ref_mul(x, y, mode);
    wb_write(`REG_X, x);
    wb_write(`REG_Y, y);
    wb_read(`REG_RESULT, got);
    check_word("result", got, want[31:0]);
    wb_read(`REG_STATUS, got);
    check_word("status", got, {27'b0, want[36:32]});
  endtask

  assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
    else stop_with_failure("ack raised without cyc and stb");
  assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
    else stop_with_failure("ack held for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) $rose(wb_req.stb) |=> wb_rsp.ack)
    else stop_with_failure("ack did not follow the strobe after one cycle");

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    stop_with_failure("timeout, the tests did not finish in time");
  end

  initial begin
    logic [31:0] rd;
    logic [36:0] want;
    logic [31:0] x;
    logic [31:0] y;
    rst_n  = 1'b0;
    wb_req = '0;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!wb_rsp.ack) else stop_with_failure("ack high before the first strobe");

    want = ref_mul(32'h0, 32'h0, `RM_RNE); // registers clear out of reset
    wb_read(`REG_RESULT, rd);
    check_word("result", rd, want[31:0]);
    wb_read(`REG_STATUS, rd);
    check_word("status", rd, {27'b0, want[36:32]});

    wb_write(`REG_X, 32'h4049_0fdb);
    wb_write(`REG_Y, 32'hc02d_f854);
    wb_write(`REG_MODE, 32'h0000_0003);
    wb_read(`REG_X, rd);
    check_word("x", rd, 32'h4049_0fdb);
    wb_read(`REG_Y, rd);
    check_word("y", rd, 32'hc02d_f854);
    wb_read(`REG_MODE, rd);
    check_word("mode", rd, 32'h0000_0003);
    for (int a = 5; a < 8; a++) begin
      wb_read(a[2:0], rd);
      check_word("unmapped", rd, 32'h0);
    end
    wb_write(`REG_RESULT, 32'hffff_ffff); // read only and dropped
    wb_write(`REG_STATUS, 32'hffff_ffff);
    want = ref_mul(32'h4049_0fdb, 32'hc02d_f854, `RM_RUP);
    wb_read(`REG_RESULT, rd);
    check_word("result", rd, want[31:0]);

    wb_write(`REG_MODE, {29'b0, `RM_RNE});
    for (int i = 0; i < N_RNE; i++) begin
      x = rand_normal(1'b0);
      y = rand_normal(1'b0);
      check_pair(x, y, `RM_RNE);
    end

    for (int m = 0; m < 6; m++) begin
      wb_write(`REG_MODE, m);
      wb_read(`REG_MODE, rd);
      check_word("mode", rd, m);
      check_pair(32'h3f80_0001, 32'hbfc0_0000, m[2:0]); // tie with odd lsb
      check_pair(32'h3f80_0003, 32'h3fc0_0000, m[2:0]); // tie with even lsb
      for (int i = 0; i < N_MODE; i++) begin
        x = rand_normal(1'b1);
        y = rand_normal(1'b1);
        check_pair(x, y, m[2:0]);
      end
    end

    wb_write(`REG_MODE, {29'b0, `RM_RNE});
    for (int i = 0; i < N_SPECIAL; i++) begin
      check_pair(SPECIAL[i][63:32], SPECIAL[i][31:0], `RM_RNE);
    end
    for (int i = 0; i < N_RANGE; i++) begin
      x = next_rand();
      y = next_rand();
      check_pair({x[31], RANGE_EXP[i][15:8], x[30:8]}, {y[31], RANGE_EXP[i][7:0], y[30:8]},
                 `RM_RNE);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* fpmul.f */
+incdir+.
+incdir+sim
source/fpmul_pkg.sv
source/fpmul_wb_ctrl.sv
source/booth_pp_gen.sv
source/pp_sum_tree.sv
source/fp_norm_round.sv
source/fp_exp_except.sv
source/fpmul_top.sv
sim/tb_fpmul.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_fpmul -f fpmul.f -o tb_fpmul_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/tb_fpmul_sim > sim.log 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status, see sim.log"
  exit 1
fi

if grep -qx "RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
